// File: verilog/line_engine_defs.svh
/*
  Frame-buffer geometry, data widths and AXI4-Lite register offsets.
  Include wherever these constants are needed.
*/
`ifndef LINE_ENGINE_DEFS_SVH
`define LINE_ENGINE_DEFS_SVH

// Frame-buffer geometry
`define FB_WIDTH      64
`define FB_HEIGHT     32
`define FB_X_BITS     6
`define FB_Y_BITS     5
`define FB_ADDR_BITS  11

// Data widths
`define COORD_BITS    16
`define COLOR_BITS    8

// Register map, byte offsets on the AXI bus
`define REG_CTRL      8'h00 // W: bit0 line start, bit1 clear
`define REG_STATUS    8'h04 // R: bit0 busy
`define REG_P0        8'h08 // {y0, x0}
`define REG_P1        8'h0C // {y1, x1}
`define REG_COLOR     8'h10
`define REG_FB_INDEX  8'h14 // y * 64 + x
`define REG_FB_DATA   8'h18 // R: pixel at index

`endif

// File: verilog/line_engine_pkg.sv
/*
  Shared types of the line engine: AXI4-Lite channels, line command,
  span, and the frame-buffer address seen as index or as x/y pair.
*/
`include "line_engine_defs.svh"

package line_engine_pkg;

  // AXI4-Lite channels, ready travels separately
  typedef struct packed {
    logic       valid;
    logic [7:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } axil_w_t;

  typedef struct packed {
    logic       valid;
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic [1:0]  resp;
  } axil_r_t;

  typedef struct packed {
    logic [`COORD_BITS-1:0] x0;
    logic [`COORD_BITS-1:0] y0;
    logic [`COORD_BITS-1:0] x1;
    logic [`COORD_BITS-1:0] y1;
    logic [`COLOR_BITS-1:0] color;
  } line_cmd_t;

  typedef struct packed {
    logic [`COORD_BITS-1:0] x;
    logic [`COORD_BITS-1:0] y;
    logic [`COORD_BITS-1:0] len;      // At least 1
    logic                   vertical; // Steps y instead of x
    logic [`COLOR_BITS-1:0] color;
  } span_t;

  typedef struct packed {
    logic [`FB_Y_BITS-1:0] y;
    logic [`FB_X_BITS-1:0] x;
  } fb_xy_t;

  // Same bits, y above x, so xy and index agree
  typedef union packed {
    logic [`FB_ADDR_BITS-1:0] index;
    fb_xy_t                   xy;
  } fb_addr_u;

endpackage

// File: verilog/axil_line_regs.sv
/*
  AXI4-Lite slave for the line engine. Holds end points, colour and
  pixel index, issues start and clear pulses, and reads pixels back.
*/
`timescale 1ns/1ps
`include "line_engine_defs.svh"

module axil_line_regs import line_engine_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  axil_aw_t               aw,
  output logic                   awready,
  input  axil_w_t                w,
  output logic                   wready,
  output axil_b_t                b,
  input  logic                   bready,
  input  axil_ar_t               ar,
  output logic                   arready,
  output axil_r_t                r,
  input  logic                   rready,
  output line_cmd_t              cmd,
  output logic                   start,
  output logic                   clear,
  input  logic                   busy,
  output fb_addr_u               fb_raddr,
  input  logic [`COLOR_BITS-1:0] fb_rdata
);

  logic [31:0]               p0_q;
  logic [31:0]               p1_q;
  logic [`COLOR_BITS-1:0]    color_q;
  logic [`FB_ADDR_BITS-1:0]  index_q;
  logic                      bvalid_q;
  logic                      rvalid_q;
  logic                      rd_wait_q; // Memory read in flight
  logic [31:0]               rdata_q;
  logic                      start_q;
  logic                      clear_q;
  logic                      wr_fire;
  logic                      rd_fire;
  logic                      blocked;
  logic [31:0]               rd_word;

  // Both readies high only when AW and W agree, so neither handshakes alone
  assign awready = !bvalid_q && (aw.valid == w.valid);
  assign wready  = awready;
  assign wr_fire = aw.valid && w.valid && !bvalid_q;

  assign arready = !rvalid_q && !rd_wait_q;
  assign rd_fire = ar.valid && arready;

  // A pulse already issued counts as busy too
  assign blocked = busy || start_q || clear_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
      start_q  <= 1'b0;
      clear_q  <= 1'b0;
    end else begin
      start_q <= 1'b0;
      clear_q <= 1'b0;
      if (bvalid_q && bready)
        bvalid_q <= 1'b0;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
        if (aw.addr == `REG_CTRL && !blocked) begin
          start_q <= w.data[0];
          clear_q <= w.data[1];
        end
      end
    end
  end

  // Configuration words
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      case (aw.addr)
        `REG_P0:       p0_q    <= w.data;
        `REG_P1:       p1_q    <= w.data;
        `REG_COLOR:    color_q <= w.data[`COLOR_BITS-1:0];
        `REG_FB_INDEX: index_q <= w.data[`FB_ADDR_BITS-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (ar.addr)
      `REG_STATUS:   rd_word = {31'b0, busy};
      `REG_P0:       rd_word = p0_q;
      `REG_P1:       rd_word = p1_q;
      `REG_COLOR:    rd_word = {{(32-`COLOR_BITS){1'b0}}, color_q};
      `REG_FB_INDEX: rd_word = {{(32-`FB_ADDR_BITS){1'b0}}, index_q};
      default:       rd_word = 32'b0; // CTRL is write-only
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid_q  <= 1'b0;
      rd_wait_q <= 1'b0;
    end else begin
      if (rvalid_q && rready)
        rvalid_q <= 1'b0;
      if (rd_wait_q) begin
        rd_wait_q <= 1'b0;
        rvalid_q  <= 1'b1;
      end else if (rd_fire) begin
        if (ar.addr == `REG_FB_DATA)
          rd_wait_q <= 1'b1;
        else
          rvalid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_wait_q)
      rdata_q <= {{(32-`COLOR_BITS){1'b0}}, fb_rdata}; // Memory data now valid
    else if (rd_fire)
      rdata_q <= rd_word;
  end

  assign b.valid = bvalid_q;
  assign b.resp  = 2'b00;
  assign r.valid = rvalid_q;
  assign r.data  = rdata_q;
  assign r.resp  = 2'b00;

  assign cmd.x0    = p0_q[`COORD_BITS-1:0];
  assign cmd.y0    = p0_q[2*`COORD_BITS-1:`COORD_BITS];
  assign cmd.x1    = p1_q[`COORD_BITS-1:0];
  assign cmd.y1    = p1_q[2*`COORD_BITS-1:`COORD_BITS];
  assign cmd.color = color_q;

  assign start = start_q;
  assign clear = clear_q;

  assign fb_raddr.index = index_q;

endmodule

// File: verilog/draw_line.sv
/*
  Bresenham line stepper. Captures a line command on start and emits
  runs of pixels on one minor coordinate as horizontal or vertical spans.
*/
`timescale 1ns/1ps
`include "line_engine_defs.svh"

module draw_line import line_engine_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  line_cmd_t cmd,
  output span_t     span,
  output logic      span_valid,
  input  logic      span_ready,
  output logic      busy
);

  typedef enum logic [2:0] {
    DL_IDLE,
    DL_SWAP,  // Steep lines swap axes
    DL_ORDER, // Order end points by major axis
    DL_INIT,
    DL_RUN,
    DL_LAST   // Final span waiting for accept
  } dl_state_e;

  dl_state_e              state;
  logic [`COORD_BITS-1:0] mx0;
  logic [`COORD_BITS-1:0] my0;
  logic [`COORD_BITS-1:0] mx1;
  logic [`COORD_BITS-1:0] my1;
  logic [`COORD_BITS-1:0] dx;
  logic [`COORD_BITS-1:0] dy;
  logic [`COORD_BITS-1:0] err;
  logic [`COORD_BITS-1:0] run_x; // First major coordinate of current run
  logic [`COLOR_BITS-1:0] color_q;
  logic                   steep;
  logic                   ystep;
  span_t                  span_q;
  logic                   span_valid_q;
  logic                   can_emit;

  // Builds a span from a run, swapping axes back for steep lines
  function automatic span_t make_span(
    input logic [`COORD_BITS-1:0] first,
    input logic [`COORD_BITS-1:0] minor,
    input logic [`COORD_BITS-1:0] last,
    input logic                   is_steep,
    input logic [`COLOR_BITS-1:0] color
  );
    span_t s;
    s.x        = is_steep ? minor : first;
    s.y        = is_steep ? first : minor;
    s.len      = last - first + 1'b1;
    s.vertical = is_steep;
    s.color    = color;
    return s;
  endfunction

  assign can_emit = !span_valid_q || span_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= DL_IDLE;
      span_valid_q <= 1'b0;
    end else begin
      if (span_valid_q && span_ready)
        span_valid_q <= 1'b0;
      case (state)
        DL_IDLE: begin
          if (start) begin
            mx0     <= cmd.x0;
            my0     <= cmd.y0;
            mx1     <= cmd.x1;
            my1     <= cmd.y1;
            color_q <= cmd.color;
            dx      <= (cmd.x1 > cmd.x0) ? cmd.x1 - cmd.x0 : cmd.x0 - cmd.x1;
            dy      <= (cmd.y1 > cmd.y0) ? cmd.y1 - cmd.y0 : cmd.y0 - cmd.y1;
            state   <= DL_SWAP;
          end
        end
        DL_SWAP: begin
          steep <= dy > dx;
          if (dy > dx) begin
            mx0 <= my0;
            my0 <= mx0;
            mx1 <= my1;
            my1 <= mx1;
            dx  <= dy;
            dy  <= dx;
          end
          state <= DL_ORDER;
        end
        DL_ORDER: begin
          if (mx0 > mx1) begin
            mx0 <= mx1;
            mx1 <= mx0;
            my0 <= my1;
            my1 <= my0;
          end
          err   <= dx >> 1;
          state <= DL_INIT;
        end
        DL_INIT: begin
          ystep <= my0 < my1; // 1 steps minor upward
          run_x <= mx0;
          state <= DL_RUN;
        end
        DL_RUN: begin
          if (can_emit) begin
            if (mx0 == mx1) begin
              span_q       <= make_span(run_x, my0, mx0, steep, color_q);
              span_valid_q <= 1'b1;
              state        <= DL_LAST;
            end else if (err < dy) begin // Minor coordinate moves next
              span_q       <= make_span(run_x, my0, mx0, steep, color_q);
              span_valid_q <= 1'b1;
              my0          <= ystep ? my0 + 1'b1 : my0 - 1'b1;
              err          <= err - dy + dx;
              run_x        <= mx0 + 1'b1;
              mx0          <= mx0 + 1'b1;
            end else begin
              err <= err - dy; // Run continues
              mx0 <= mx0 + 1'b1;
            end
          end
        end
        DL_LAST: begin
          if (span_ready)
            state <= DL_IDLE;
        end
        default: state <= DL_IDLE;
      endcase
    end
  end

  assign span       = span_q;
  assign span_valid = span_valid_q;
  assign busy       = (state != DL_IDLE);

endmodule

// File: verilog/span_writer.sv
/*
  Turns spans into one pixel write per cycle and sweeps the whole
  frame buffer on clear. Off-screen pixels are not written.
*/
`timescale 1ns/1ps
`include "line_engine_defs.svh"

module span_writer import line_engine_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  span_t                  span,
  input  logic                   span_valid,
  output logic                   span_ready,
  input  logic                   clear,
  input  logic [`COLOR_BITS-1:0] clear_color,
  output logic                   we,
  output fb_addr_u               waddr,
  output logic [`COLOR_BITS-1:0] wdata,
  output logic                   busy
);

  typedef enum logic [1:0] {SW_IDLE, SW_SPAN, SW_CLEAR} sw_state_e;

  sw_state_e                state;
  logic [`COORD_BITS-1:0]   px;
  logic [`COORD_BITS-1:0]   py;
  logic [`COORD_BITS-1:0]   cnt;     // Pixels left including current
  logic                     vert;
  logic [`COLOR_BITS-1:0]   color_q;
  logic [`FB_ADDR_BITS-1:0] clr_idx;
  logic                     on_screen;
  logic                     take;

  // Next span can load on the last pixel of the current one
  assign span_ready = !clear && (state == SW_IDLE || (state == SW_SPAN && cnt == 1));
  assign take       = span_valid && span_ready;
  assign on_screen  = (px < `COORD_BITS'(`FB_WIDTH)) && (py < `COORD_BITS'(`FB_HEIGHT));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= SW_IDLE;
      cnt     <= '0;
      clr_idx <= '0;
    end else if (clear && state == SW_IDLE) begin
      state   <= SW_CLEAR;
      clr_idx <= '0;
      color_q <= clear_color;
    end else if (take) begin
      state   <= SW_SPAN;
      px      <= span.x;
      py      <= span.y;
      cnt     <= span.len;
      vert    <= span.vertical;
      color_q <= span.color;
    end else begin
      case (state)
        SW_SPAN: begin
          if (cnt == 1)
            state <= SW_IDLE;
          else if (vert)
            py <= py + 1'b1;
          else
            px <= px + 1'b1;
          cnt <= cnt - 1'b1;
        end
        SW_CLEAR: begin
          clr_idx <= clr_idx + 1'b1;
          if (&clr_idx)
            state <= SW_IDLE; // Last index written
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    waddr = '0;
    if (state == SW_CLEAR) begin
      waddr.index = clr_idx;
    end else begin
      waddr.xy.x = px[`FB_X_BITS-1:0];
      waddr.xy.y = py[`FB_Y_BITS-1:0];
    end
  end

  assign we    = (state == SW_CLEAR) || (state == SW_SPAN && on_screen);
  assign wdata = color_q;
  assign busy  = (state != SW_IDLE);

endmodule

// File: verilog/frame_buffer.sv
/*
  Pixel memory of 64 x 32 colours. One write port from the span writer
  and one synchronous read port for register readback.
*/
`timescale 1ns/1ps
`include "line_engine_defs.svh"

module frame_buffer import line_engine_pkg::*; (
  input  logic                   clk,
  input  logic                   we,
  input  fb_addr_u               waddr,
  input  logic [`COLOR_BITS-1:0] wdata,
  input  fb_addr_u               raddr,
  output logic [`COLOR_BITS-1:0] rdata
);

  localparam int DEPTH = `FB_WIDTH * `FB_HEIGHT;

  logic [`COLOR_BITS-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we)
      mem[waddr.index] <= wdata;
  end

  // Same-cycle read of a written address gets the old value
  always_ff @(posedge clk) begin
    rdata <= mem[raddr.index];
  end

endmodule

// File: verilog/line_engine_top.sv
/*
  Line engine top level. AXI4-Lite registers drive a Bresenham stepper,
  whose spans are written into the on-chip frame buffer.
*/
`timescale 1ns/1ps
`include "line_engine_defs.svh"

module line_engine_top import line_engine_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  axil_aw_t aw,
  output logic     awready,
  input  axil_w_t  w,
  output logic     wready,
  output axil_b_t  b,
  input  logic     bready,
  input  axil_ar_t ar,
  output logic     arready,
  output axil_r_t  r,
  input  logic     rready
);

  line_cmd_t              cmd;
  logic                   start;
  logic                   clear;
  logic                   busy;
  logic                   dl_busy;
  logic                   sw_busy;
  span_t                  span;
  logic                   span_valid;
  logic                   span_ready;
  logic                   fb_we;
  fb_addr_u               fb_waddr;
  logic [`COLOR_BITS-1:0] fb_wdata;
  fb_addr_u               fb_raddr;
  logic [`COLOR_BITS-1:0] fb_rdata;

  assign busy = dl_busy | sw_busy; // Either stage still drawing

  axil_line_regs i_axil_line_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw       (aw),
    .awready  (awready),
    .w        (w),
    .wready   (wready),
    .b        (b),
    .bready   (bready),
    .ar       (ar),
    .arready  (arready),
    .r        (r),
    .rready   (rready),
    .cmd      (cmd),
    .start    (start),
    .clear    (clear),
    .busy     (busy),
    .fb_raddr (fb_raddr),
    .fb_rdata (fb_rdata)
  );

  draw_line i_draw_line (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .cmd        (cmd),
    .span       (span),
    .span_valid (span_valid),
    .span_ready (span_ready),
    .busy       (dl_busy)
  );

  span_writer i_span_writer (
    .clk         (clk),
    .rst_n       (rst_n),
    .span        (span),
    .span_valid  (span_valid),
    .span_ready  (span_ready),
    .clear       (clear),
    .clear_color (cmd.color),
    .we          (fb_we),
    .waddr       (fb_waddr),
    .wdata       (fb_wdata),
    .busy        (sw_busy)
  );

  frame_buffer i_frame_buffer (
    .clk   (clk),
    .we    (fb_we),
    .waddr (fb_waddr),
    .wdata (fb_wdata),
    .raddr (fb_raddr),
    .rdata (fb_rdata)
  );

endmodule

// File: tests/tb_clock_gen.sv
/*
  Testbench clock and reset. 4 ns clock, rst_n held low for the
  first 10 rising edges, then released on an edge.
*/
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: tests/tb_line_engine.sv
/*
  Testbench for the line engine. Drives the AXI4-Lite port, draws lines
  against a reference rasterizer and compares the whole frame buffer.
*/
`timescale 1ns/1ps
`include "line_engine_defs.svh"

module tb_line_engine import line_engine_pkg::*; ();

  localparam int HS_LIMIT    = 50;    // Cycles per AXI handshake
  localparam int BUSY_LIMIT  = 5000;
  localparam int CHECK_LIMIT = 60000; // Full readback of 2048 pixels
  localparam int FB_PIXELS   = `FB_WIDTH * `FB_HEIGHT;

  logic                   clk;
  logic                   rst_n;
  axil_aw_t               aw;
  logic                   awready;
  axil_w_t                w;
  logic                   wready;
  axil_b_t                b;
  logic                   bready;
  axil_ar_t               ar;
  logic                   arready;
  axil_r_t                r;
  logic                   rready;
  logic [`COLOR_BITS-1:0] model [FB_PIXELS];
  logic [15:0]            lfsr;
  logic                   timed_out = 1'b0;
  logic                   check_busy = 1'b0; // Request to the checking process
  int                     errors = 0;
  int                     errors_at_start;
  int                     tests_run = 0;
  int                     tests_failed = 0;
  int                     cycle = 0;

  tb_clock_gen i_tb_clock_gen (.clk(clk), .rst_n(rst_n));

  line_engine_top i_line_engine_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .aw      (aw),
    .awready (awready),
    .w       (w),
    .wready  (wready),
    .b       (b),
    .bready  (bready),
    .ar      (ar),
    .arready (arready),
    .r       (r),
    .rready  (rready)
  );

  always @(posedge clk) cycle <= cycle + 1;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    int          i;
    v = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  function automatic void ref_clear(input logic [`COLOR_BITS-1:0] color);
    int i;
    for (i = 0; i < FB_PIXELS; i++)
      model[i] = color;
  endfunction

  // Bresenham on the model with off-screen pixels dropped
  function automatic void ref_line(input int x0, input int y0, input int x1, input int y1,
                                   input logic [`COLOR_BITS-1:0] color);
    int dx;
    int dy;
    int err;
    int t;
    int x;
    int y;
    int px;
    int py;
    bit steep;
    bit up;
    dx    = (x1 > x0) ? x1 - x0 : x0 - x1;
    dy    = (y1 > y0) ? y1 - y0 : y0 - y1;
    steep = dy > dx;
    if (steep) begin
      t  = x0;
      x0 = y0;
      y0 = t;
      t  = x1;
      x1 = y1;
      y1 = t;
      t  = dx;
      dx = dy;
      dy = t;
    end
    if (x0 > x1) begin
      t  = x0;
      x0 = x1;
      x1 = t;
      t  = y0;
      y0 = y1;
      y1 = t;
    end
    err = dx / 2;
    up  = y0 < y1;
    y   = y0;
    for (x = x0; x <= x1; x++) begin
      px = steep ? y : x;
      py = steep ? x : y;
      if (px >= 0 && px < `FB_WIDTH && py >= 0 && py < `FB_HEIGHT)
        model[py * `FB_WIDTH + px] = color;
      if (err < dy) begin
        y   = up ? y + 1 : y - 1; // Minor axis steps
        err = err - dy + dx;
      end else begin
        err = err - dy;
      end
    end
  endfunction

  task automatic note_timeout(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    timed_out = 1'b1;
  endtask

  task automatic check_color(input logic [`COLOR_BITS-1:0] got,
                             input logic [`COLOR_BITS-1:0] exp, input string what);
    if (!timed_out && got !== exp) begin
      errors++;
      $display("Fail %0t ns: %s read %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
    if (!timed_out && got !== exp) begin
      errors++;
      $display("Fail %0t ns: %s read %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input logic [1:0] got, input logic [1:0] exp,
                            input string what);
    if (!timed_out && got !== exp) begin
      errors++;
      $display("Fail %0t ns: %s was %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Called on a rising edge and returns on one
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    int n;
    if (timed_out)
      return;
    aw <= '{valid: 1'b1, addr: addr};
    w  <= '{valid: 1'b1, data: data};
    n  = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!(awready && wready) && n < HS_LIMIT);
    aw <= '0;
    w  <= '0;
    if (!(awready && wready)) begin
      note_timeout("AW/W ready");
      return;
    end
    bready <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!b.valid && n < HS_LIMIT);
    bready <= 1'b0;
    if (b.valid)
      check_resp(b.resp, 2'b00, "write response");
    else
      note_timeout("write response");
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    int n;
    data = '0;
    if (timed_out)
      return;
    ar <= '{valid: 1'b1, addr: addr};
    n  = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!arready && n < HS_LIMIT);
    ar <= '0;
    if (!arready) begin
      note_timeout("AR ready");
      return;
    end
    rready <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!r.valid && n < HS_LIMIT);
    rready <= 1'b0;
    if (r.valid) begin
      data = r.data;
      check_resp(r.resp, 2'b00, "read response");
    end else begin
      note_timeout("read data");
    end
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    int          t0;
    t0     = cycle;
    status = 32'h1;
    while (status[0] && !timed_out) begin
      axi_read(`REG_STATUS, status);
      if (status[0] && cycle - t0 > BUSY_LIMIT)
        note_timeout("busy to fall");
    end
  endtask

  task automatic clear_fb(input logic [`COLOR_BITS-1:0] color);
    axi_write(`REG_COLOR, {24'h0, color});
    axi_write(`REG_CTRL, 32'h2);
    wait_idle();
    ref_clear(color);
  endtask

  task automatic draw(input int x0, input int y0, input int x1, input int y1,
                      input logic [`COLOR_BITS-1:0] color);
    axi_write(`REG_P0, {y0[15:0], x0[15:0]});
    axi_write(`REG_P1, {y1[15:0], x1[15:0]});
    axi_write(`REG_COLOR, {24'h0, color});
    axi_write(`REG_CTRL, 32'h1);
    wait_idle();
    ref_line(x0, y0, x1, y1, color);
  endtask

  task automatic compare_buffer();
    logic [31:0] word;
    int          i;
    for (i = 0; i < FB_PIXELS && !timed_out; i++) begin
      axi_write(`REG_FB_INDEX, i);
      axi_read(`REG_FB_DATA, word);
      check_color(word[`COLOR_BITS-1:0], model[i],
                  $sformatf("pixel x=%0d y=%0d", i % `FB_WIDTH, i / `FB_WIDTH));
    end
  endtask

  // Hands the readback to the checking process and waits for it
  task automatic verify_buffer();
    int n;
    check_busy = 1'b1;
    n = 0;
    while (check_busy && !timed_out) begin
      @(posedge clk);
      n++;
      if (n > CHECK_LIMIT)
        note_timeout("frame-buffer readback");
    end
  endtask

  always @(posedge clk) begin
    if (check_busy) begin
      compare_buffer();
      check_busy = 1'b0;
    end
  end

  task automatic end_test(input string name);
    tests_run++;
    if (errors != errors_at_start || timed_out) begin
      tests_failed++;
      $display("Test %s: FAILED with %0d errors", name, errors - errors_at_start);
    end else begin
      $display("Test %s: ok", name);
    end
    errors_at_start = errors;
  endtask

  initial begin
    logic [31:0] word;
    logic [31:0] p0;
    logic [31:0] p1;
    logic [7:0]  col;
    int          n;
    aw              = '0;
    w               = '0;
    ar              = '0;
    bready          = 1'b0;
    rready          = 1'b0;
    lfsr            = 16'd51429;
    errors_at_start = 0;
    n               = 0;
    while (!rst_n && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (!rst_n)
      note_timeout("reset release");
    @(posedge clk);

    axi_read(`REG_STATUS, word);
    check_word(word, 32'h0, "STATUS after reset");
    p0  = rand_bits(32);
    p1  = rand_bits(32);
    col = rand_bits(8);
    axi_write(`REG_P0, p0);
    axi_write(`REG_P1, p1);
    axi_write(`REG_COLOR, {24'h0, col});
    axi_read(`REG_P0, word);
    check_word(word, p0, "P0");
    axi_read(`REG_P1, word);
    check_word(word, p1, "P1");
    axi_read(`REG_COLOR, word);
    check_word(word, {24'h0, col}, "COLOR");
    axi_read(`REG_CTRL, word);
    check_word(word, 32'h0, "CTRL readback");
    axi_read(8'h1C, word);
    check_word(word, 32'h0, "unknown offset");
    end_test("register readback");

    clear_fb(rand_bits(8));
    verify_buffer();
    end_test("clear");

    clear_fb(rand_bits(8));
    repeat (20) begin
      draw(rand_bits(6), rand_bits(5), rand_bits(6), rand_bits(5), rand_bits(8));
      verify_buffer();
    end
    end_test("random lines");

    clear_fb(rand_bits(8));
    draw(5, 7, 50, 7, 8'h21);     // Horizontal
    verify_buffer();
    draw(20, 2, 20, 30, 8'h42);   // Vertical
    verify_buffer();
    draw(10, 1, 17, 29, 8'h63);   // Steep
    verify_buffer();
    draw(60, 25, 3, 4, 8'h84);    // Reversed
    verify_buffer();
    draw(40, 31, 35, 0, 8'ha5);   // Reversed and steep
    verify_buffer();
    draw(33, 16, 33, 16, 8'hc6);  // Single point
    verify_buffer();
    end_test("special shapes");

    // Second start and clear land while the first line is still drawing
    clear_fb(rand_bits(8));
    axi_write(`REG_P0, {16'd3, 16'd0});
    axi_write(`REG_P1, {16'd3, 16'd63});
    axi_write(`REG_COLOR, 32'h5a);
    axi_write(`REG_CTRL, 32'h1);
    axi_read(`REG_STATUS, word);
    check_word(word, 32'h1, "STATUS while drawing");
    axi_write(`REG_P0, {16'd10, 16'd0});
    axi_write(`REG_P1, {16'd20, 16'd63});
    axi_write(`REG_COLOR, 32'ha5);
    axi_write(`REG_CTRL, 32'h3);
    wait_idle();
    ref_line(0, 3, 63, 3, 8'h5a);
    verify_buffer();
    end_test("ignored start");

    clear_fb(rand_bits(8));
    draw(40, 10, 100, 50, 8'h3c);
    draw(10, 20, 30, 70, 8'hc3);
    verify_buffer();
    end_test("clipping");

    $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && !timed_out)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// File: line_engine.f
+incdir+verilog
verilog/line_engine_pkg.sv
verilog/axil_line_regs.sv
verilog/draw_line.sv
verilog/span_writer.sv
verilog/frame_buffer.sv
verilog/line_engine_top.sv
tests/tb_clock_gen.sv
tests/tb_line_engine.sv
